//--- flist.f
+incdir+test
design/periph_pkg.sv
design/periph_addr_decode.sv
design/read_return.sv
design/gpio_ctrl.sv
design/pin_func_mux.sv
design/scratch_regs.sv
design/byte_regs.sv
design/periph_top.sv
test/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_block

sources:
  - design/periph_pkg.sv
  - design/periph_addr_decode.sv
  - design/read_return.sv
  - design/gpio_ctrl.sv
  - design/pin_func_mux.sv
  - design/scratch_regs.sv
  - design/byte_regs.sv
  - design/periph_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_periph_top.sv

//--- test/tb_bus_tasks.svh
/*
 * Bus read/write tasks, LFSR data source and register reference model.
 * Included inside the body of the peripheral testbench module.
 */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

logic [15:0] lfsr;
logic [31:0] scratch_model [4];
logic [7:0]  byte_model [4];
logic [7:0]  gpio_out_model;
logic [4:0]  func_model [8];

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
        fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr  = {lfsr[14:0], fb};
        value = {value[30:0], fb};
    end
    return value;
endfunction

function automatic logic [ADDR_W-1:0] user_addr(input int slot, input int offset);
    return ADDR_W'((slot << USER_SLOT_LSB) + offset);
endfunction

function automatic logic [ADDR_W-1:0] simple_addr(input int slot, input int offset);
    return ADDR_W'((1 << SIMPLE_SPACE_BIT) + (slot << SIMPLE_SLOT_LSB) + offset);
endfunction

// Sized writes only touch the low bits of the register
function automatic void model_scratch_write(input int idx, input access_size_e size,
                                            input logic [31:0] data);
    case (size)
        SIZE_BYTE: scratch_model[idx][7:0]  = data[7:0];
        SIZE_HALF: scratch_model[idx][15:0] = data[15:0];
        SIZE_WORD: scratch_model[idx]       = data;
        default:   ;
    endcase
endfunction

// Pin i shows bit i of whichever source its select names, else zero
function automatic logic [7:0] expected_pins();
    logic [7:0] pins;
    pins = '0;
    for (int i = 0; i < 8; i++) begin
        if (func_model[i] == 5'h01) begin
            pins[i] = gpio_out_model[i];
        end else if (func_model[i] == 5'h04) begin
            pins[i] = scratch_model[0][i];
        end else if (func_model[i] == 5'h10) begin
            pins[i] = byte_model[1][i];
        end
    end
    return pins;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    $display("[ERROR] %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, got);
    err_count++;
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    assert (got === exp) else report_mismatch(name, exp, got);
endtask

// Single-cycle write, returns on the falling edge after it
task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                         input access_size_e size);
    @(negedge clk);
    req.addr       = addr;
    req.wdata      = data;
    req.write_size = size;
    req.read_size  = SIZE_NONE;
    @(negedge clk);
    req.write_size = SIZE_NONE;
endtask

task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [31:0] exp_data,
                        input int exp_lat);
    int lat;
    lat = 0;
    @(negedge clk);
    req.addr      = addr;
    req.wdata     = '0;
    req.read_size = SIZE_WORD;
    do begin
        @(negedge clk);
        lat++;
    end while (!data_ready && lat < READ_WAIT_MAX);
    if (!data_ready) begin
        $display("Read at address 0x%h got no data_ready within %0d cycles", addr, lat);
        err_count++;
    end
    check_value("read latency", 32'(exp_lat), 32'(lat));
    check_value("o_rdata", exp_data, rdata);
    // Drop the request, keep the data one idle cycle, then complete the read
    req.read_size = SIZE_NONE;
    holding       = 1'b1;
    @(negedge clk);
    check_value("o_data_ready", 32'd0, {31'd0, data_ready});
    read_complete = 1'b1;
    @(negedge clk);
    read_complete = 1'b0;
    holding       = 1'b0;
endtask

`endif

//--- test/tb_periph_top.sv
/*
 * Testbench for the peripheral block top level. Runs reset, GPIO, scratch,
 * byte peripheral and pin routing tests and prints a summary line.
 */
`timescale 1ns/1ps

module tb_periph_top;
    import periph_pkg::*;

    // Bus operations issued by the test sequence
    localparam int OP_COUNT      = 61;
    localparam int CYCLE_LIMIT   = 40 * OP_COUNT;
    localparam int READ_WAIT_MAX = 20;

    logic              clk;
    logic              rst_n;
    bus_req_t          req;
    logic              read_complete;
    logic [PIN_W-1:0]  ui_in;
    logic [DATA_W-1:0] rdata;
    logic              data_ready;
    logic [PIN_W-1:0]  uo_out;
    logic              holding;
    int                err_count;
    int                check_count;
    int                tests_run;
    int                tests_passed;
    int                test_err_start;
    int                cycle_count = 0;

    `include "tb_bus_tasks.svh"

    periph_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_read_complete (read_complete),
        .i_ui_in         (ui_in),
        .o_rdata         (rdata),
        .o_data_ready    (data_ready),
        .o_uo_out        (uo_out)
    );

    always #10 clk = ~clk;

    // Writes are acknowledged in the cycle they are issued
    assert property (@(negedge clk) disable iff (!rst_n)
        req.write_size != SIZE_NONE |-> data_ready)
        else report_mismatch("o_data_ready", 32'd1, {31'd0, $sampled(data_ready)});

    // Returned data must not move before read complete
    assert property (@(negedge clk) disable iff (!rst_n) holding |-> $stable(rdata))
        else report_mismatch("o_rdata", $past(rdata), $sampled(rdata));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, err_count - test_err_start);
        end
        test_err_start = err_count;
    endtask

    initial begin
        logic [31:0]  data;
        logic [1:0]   sel;
        access_size_e size;
        int           idx;
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = '0;
        req.write_size = SIZE_NONE;
        req.read_size  = SIZE_NONE;
        read_complete  = 1'b0;
        ui_in          = '0;
        holding        = 1'b0;
        err_count      = 0;
        check_count    = 0;
        tests_run      = 0;
        tests_passed   = 0;
        test_err_start = 0;
        lfsr           = 16'd28969;
        gpio_out_model = '0;
        for (int i = 0; i < 4; i++) begin
            scratch_model[i] = '0;
            byte_model[i]    = '0;
        end
        for (int i = 0; i < 8; i++) begin
            func_model[i] = 5'h01;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        check_value("o_data_ready", 32'd0, {31'd0, data_ready});
        check_value("o_uo_out", 32'd0, {24'd0, uo_out});
        for (int i = 0; i < 8; i++) begin
            bus_read(user_addr(1, 'h20 + 4 * i), 32'h1, 1);
        end
        finish_test("reset");

        data = take_bits(8);
        bus_write(user_addr(1, 'h0), data, SIZE_WORD);
        gpio_out_model = data[7:0];
        check_value("o_uo_out", {24'd0, expected_pins()}, {24'd0, uo_out});
        bus_read(user_addr(1, 'h0), {24'd0, gpio_out_model}, 1);
        ui_in = PIN_W'(take_bits(8));
        bus_read(user_addr(1, 'h4), {24'd0, ui_in}, 1);
        finish_test("gpio");

        for (int n = 0; n < 12; n++) begin
            idx  = int'(take_bits(2));
            sel  = 2'(take_bits(2));
            size = (sel == 2'd0) ? SIZE_BYTE : (sel == 2'd1) ? SIZE_HALF : SIZE_WORD;
            data = take_bits(32);
            bus_write(user_addr(4, 4 * idx), data, size);
            model_scratch_write(idx, size, data);
            bus_read(user_addr(4, 4 * idx), scratch_model[idx], 2);
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(user_addr(4, 4 * i), scratch_model[i], 2);
        end
        finish_test("scratch sized writes");

        for (int i = 0; i < 4; i++) begin
            data = take_bits(32);
            bus_write(simple_addr(0, i), data, SIZE_BYTE);
            byte_model[i] = data[7:0];
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(simple_addr(0, i), {24'd0, byte_model[i]}, 1);
        end
        // Offset 4 holds no register
        bus_write(simple_addr(0, 4), take_bits(32), SIZE_BYTE);
        bus_read(simple_addr(0, 4), 32'd0, 1);
        bus_read(user_addr(7, 'h0), 32'd0, 1);
        bus_read(simple_addr(5, 'h0), 32'd0, 1);
        finish_test("byte peripheral and empty slots");

        data = take_bits(32);
        bus_write(user_addr(4, 'h0), data, SIZE_WORD);
        model_scratch_write(0, SIZE_WORD, data);
        data = take_bits(8);
        bus_write(simple_addr(0, 1), data, SIZE_BYTE);
        byte_model[1] = data[7:0];
        // Scratch, byte peripheral, two empty slots and GPIO
        func_model[0] = 5'h04;
        func_model[1] = 5'h04;
        func_model[2] = 5'h10;
        func_model[3] = 5'h10;
        func_model[4] = 5'h07;
        func_model[5] = 5'h13;
        func_model[6] = 5'h01;
        func_model[7] = 5'h01;
        for (int i = 0; i < 8; i++) begin
            bus_write(user_addr(1, 'h20 + 4 * i), {27'd0, func_model[i]}, SIZE_WORD);
        end
        check_value("o_uo_out", {24'd0, expected_pins()}, {24'd0, uo_out});
        finish_test("pin routing");

        $display("Tests run %0d, passed %0d, checks %0d, errors %0d",
                 tests_run, tests_passed, check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- design/periph_top.sv
/*
 * Peripheral block top level. Connects the address decoder, read return,
 * GPIO, the two register peripherals and the output pin multiplexer.
 */
`timescale 1ns/1ps

module periph_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  periph_pkg::bus_req_t            i_req,
    input  logic                            i_read_complete,
    input  logic [periph_pkg::PIN_W-1:0]    i_ui_in,
    output logic [periph_pkg::DATA_W-1:0]   o_rdata,
    output logic                            o_data_ready,
    output logic [periph_pkg::PIN_W-1:0]    o_uo_out
);
    import periph_pkg::*;

    slot_req_t                  gpio_req;
    slot_req_t                  scratch_req;
    slot_rsp_t                  gpio_rsp;
    slot_rsp_t                  scratch_rsp;
    slot_rsp_t                  sel_rsp;
    logic                       read_mask;
    logic                       byte_write;
    logic [SIMPLE_OFFSET_W-1:0] byte_offset;
    logic [7:0]                 byte_wdata;
    logic [7:0]                 byte_rdata;
    logic [PIN_W-1:0]           gpio_pins;
    logic [PIN_W-1:0]           scratch_pins;
    logic [PIN_W-1:0]           byte_pins;
    pin_func_t [PIN_W-1:0]      pin_func;

    periph_addr_decode u_decode (
        .i_req         (i_req),
        .i_read_mask   (read_mask),
        .i_gpio_rsp    (gpio_rsp),
        .i_scratch_rsp (scratch_rsp),
        .i_byte_rdata  (byte_rdata),
        .o_gpio_req    (gpio_req),
        .o_scratch_req (scratch_req),
        .o_byte_write  (byte_write),
        .o_byte_offset (byte_offset),
        .o_byte_wdata  (byte_wdata),
        .o_rsp         (sel_rsp)
    );

    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_size     (i_req.read_size),
        .i_write_size    (i_req.write_size),
        .i_rsp           (sel_rsp),
        .i_read_complete (i_read_complete),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready),
        .o_read_mask     (read_mask)
    );

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (gpio_req),
        .i_ui_in    (i_ui_in),
        .o_rsp      (gpio_rsp),
        .o_pins     (gpio_pins),
        .o_pin_func (pin_func)
    );

    scratch_regs u_scratch (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_req  (scratch_req),
        .o_rsp  (scratch_rsp),
        .o_pins (scratch_pins)
    );

    byte_regs u_byte (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_write  (byte_write),
        .i_offset (byte_offset),
        .i_wdata  (byte_wdata),
        .o_rdata  (byte_rdata),
        .o_pins   (byte_pins)
    );

    pin_func_mux u_pin_mux (
        .i_pin_func     (pin_func),
        .i_gpio_pins    (gpio_pins),
        .i_scratch_pins (scratch_pins),
        .i_byte_pins    (byte_pins),
        .o_uo_out       (o_uo_out)
    );

endmodule

//--- design/byte_regs.sv
/*
 * Byte-interface peripheral with four 8-bit registers at offsets 0 to 3.
 * Register 1 is also driven onto its pin outputs.
 */
`timescale 1ns/1ps

module byte_regs (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    i_write,
    input  logic [periph_pkg::SIMPLE_OFFSET_W-1:0]  i_offset,
    input  logic [7:0]                              i_wdata,
    output logic [7:0]                              o_rdata,
    output logic [periph_pkg::PIN_W-1:0]            o_pins
);
    import periph_pkg::*;

    logic [7:0] regs_q [4];
    logic       in_range;

    // Only offsets 0 to 3 hold registers
    assign in_range = i_offset[SIMPLE_OFFSET_W-1:2] == '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_write && in_range) begin
            regs_q[i_offset[1:0]] <= i_wdata;
        end
    end

    assign o_rdata = in_range ? regs_q[i_offset[1:0]] : 8'h00;
    assign o_pins  = regs_q[1];

endmodule

//--- design/scratch_regs.sv
/*
 * Full-interface scratch peripheral with four 32-bit registers. Supports byte,
 * halfword and word writes and answers reads on their second cycle.
 */
`timescale 1ns/1ps

module scratch_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  periph_pkg::slot_req_t           i_req,
    output periph_pkg::slot_rsp_t           o_rsp,
    output logic [periph_pkg::PIN_W-1:0]    o_pins
);
    import periph_pkg::*;

    logic [DATA_W-1:0] regs_q [4];
    logic [1:0]        idx;
    logic              read_req;
    logic              pending_q;

    assign idx      = i_req.offset[3:2];
    assign read_req = i_req.read_size != SIZE_NONE;

    // Set after the first cycle of a read, dropped once the read goes away
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            case (i_req.write_size)
                SIZE_BYTE: regs_q[idx][7:0]  <= i_req.wdata[7:0];
                SIZE_HALF: regs_q[idx][15:0] <= i_req.wdata[15:0];
                SIZE_WORD: regs_q[idx]       <= i_req.wdata;
                default:   ;
            endcase
        end
    end

    assign o_rsp.rdata = regs_q[idx];
    assign o_rsp.ready = pending_q && read_req;

    // Low byte of register 0 drives the pins
    assign o_pins = regs_q[0][PIN_W-1:0];

endmodule

//--- design/pin_func_mux.sv
/*
 * Per-pin output multiplexer. Each pin takes its own bit position from the
 * peripheral named by that pin's function select.
 */
`timescale 1ns/1ps

module pin_func_mux (
    input  periph_pkg::pin_func_t [periph_pkg::PIN_W-1:0]  i_pin_func,
    input  logic [periph_pkg::PIN_W-1:0]                   i_gpio_pins,
    input  logic [periph_pkg::PIN_W-1:0]                   i_scratch_pins,
    input  logic [periph_pkg::PIN_W-1:0]                   i_byte_pins,
    output logic [periph_pkg::PIN_W-1:0]                   o_uo_out
);
    import periph_pkg::*;

    always_comb begin
        for (int i = 0; i < PIN_W; i++) begin
            o_uo_out[i] = 1'b0;
            if (i_pin_func[i].is_simple) begin
                if (i_pin_func[i].slot == SLOT_BYTE) begin
                    o_uo_out[i] = i_byte_pins[i];
                end
            end else begin
                case (i_pin_func[i].slot)
                    SLOT_GPIO:    o_uo_out[i] = i_gpio_pins[i];
                    SLOT_SCRATCH: o_uo_out[i] = i_scratch_pins[i];
                    // Empty slots drive low
                    default:      o_uo_out[i] = 1'b0;
                endcase
            end
        end
    end

endmodule

//--- design/gpio_ctrl.sv
/*
 * GPIO slot with output register, input readback and per-pin output
 * function selects that steer the pin multiplexer.
 */
`timescale 1ns/1ps

module gpio_ctrl (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  periph_pkg::slot_req_t                             i_req,
    input  logic [periph_pkg::PIN_W-1:0]                      i_ui_in,
    output periph_pkg::slot_rsp_t                             o_rsp,
    output logic [periph_pkg::PIN_W-1:0]                      o_pins,
    output periph_pkg::pin_func_t [periph_pkg::PIN_W-1:0]     o_pin_func
);
    import periph_pkg::*;

    logic                   write_en;
    logic                   is_func_ofs;
    logic [2:0]             func_idx;
    logic [PIN_W-1:0]       out_q;
    pin_func_t [PIN_W-1:0]  func_q;

    assign write_en = i_req.write_size != SIZE_NONE;

    // Function selects at 0x20, 0x24 ... 0x3c
    assign is_func_ofs = i_req.offset[5] && i_req.offset[1:0] == 2'b00;
    assign func_idx    = i_req.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (write_en && i_req.offset == GPIO_OUT_OFS) begin
            out_q <= i_req.wdata[PIN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Every pin starts on the GPIO output register
            for (int i = 0; i < PIN_W; i++) begin
                func_q[i] <= '{is_simple: 1'b0, slot: SLOT_GPIO};
            end
        end else if (write_en && is_func_ofs) begin
            func_q[func_idx] <= pin_func_t'(i_req.wdata[4:0]);
        end
    end

    always_comb begin
        o_rsp.rdata = '0;
        o_rsp.ready = 1'b1;
        if (i_req.offset == GPIO_OUT_OFS) begin
            o_rsp.rdata[PIN_W-1:0] = out_q;
        end else if (i_req.offset == GPIO_IN_OFS) begin
            o_rsp.rdata[PIN_W-1:0] = i_ui_in;
        end else if (is_func_ofs) begin
            o_rsp.rdata[4:0] = func_q[func_idx];
        end
    end

    assign o_pins     = out_q;
    assign o_pin_func = func_q;

endmodule

//--- design/read_return.sv
/*
 * Registered read return to the core. Read data is captured once per read and
 * held until the core signals read complete.
 */
`timescale 1ns/1ps

module read_return (
    input  logic                             clk,
    input  logic                             rst_n,
    input  periph_pkg::access_size_e         i_read_size,
    input  periph_pkg::access_size_e         i_write_size,
    input  periph_pkg::slot_rsp_t            i_rsp,
    input  logic                             i_read_complete,
    output logic [periph_pkg::DATA_W-1:0]    o_rdata,
    output logic                             o_data_ready,
    output logic                             o_read_mask
);
    import periph_pkg::*;

    logic              read_req;
    logic              capture;
    logic              hold_q;
    logic              ready_q;
    logic [DATA_W-1:0] rdata_q;

    assign read_req = i_read_size != SIZE_NONE;

    // Take the first ready response of a read only
    assign capture = !hold_q && read_req && i_rsp.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Ready follows the registered data by design
            ready_q <= read_req && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= i_rsp.rdata;
        end
    end

    assign o_rdata = rdata_q;

    // Writes complete in the cycle they are issued
    assign o_data_ready = ready_q || i_write_size != SIZE_NONE;
    assign o_read_mask  = ready_q;

endmodule

//--- design/periph_addr_decode.sv
/*
 * Splits the peripheral address into space and slot, gates each slot's request
 * and returns the response of the addressed slot.
 */
`timescale 1ns/1ps

module periph_addr_decode (
    input  periph_pkg::bus_req_t                    i_req,
    input  logic                                    i_read_mask,
    input  periph_pkg::slot_rsp_t                   i_gpio_rsp,
    input  periph_pkg::slot_rsp_t                   i_scratch_rsp,
    input  logic [7:0]                              i_byte_rdata,
    output periph_pkg::slot_req_t                   o_gpio_req,
    output periph_pkg::slot_req_t                   o_scratch_req,
    output logic                                    o_byte_write,
    output logic [periph_pkg::SIMPLE_OFFSET_W-1:0]  o_byte_offset,
    output logic [7:0]                              o_byte_wdata,
    output periph_pkg::slot_rsp_t                   o_rsp
);
    import periph_pkg::*;

    logic              is_simple;
    logic [SLOT_W-1:0] user_slot;
    logic [SLOT_W-1:0] simple_slot;
    access_size_e      rd_size;

    // Request for one user slot, idle when the slot is not addressed
    function automatic slot_req_t gate_req(input bus_req_t req, input access_size_e rd,
                                           input logic sel);
        slot_req_t gated;
        gated.offset     = req.addr[USER_OFFSET_W-1:0];
        gated.wdata      = req.wdata;
        gated.write_size = sel ? req.write_size : SIZE_NONE;
        gated.read_size  = sel ? rd : SIZE_NONE;
        return gated;
    endfunction

    assign is_simple   = i_req.addr[SIMPLE_SPACE_BIT];
    assign user_slot   = i_req.addr[USER_SLOT_LSB +: SLOT_W];
    assign simple_slot = i_req.addr[SIMPLE_SLOT_LSB +: SLOT_W];

    // No second read while a returned word is waiting
    assign rd_size = i_read_mask ? SIZE_NONE : i_req.read_size;

    assign o_gpio_req    = gate_req(i_req, rd_size, !is_simple && user_slot == SLOT_GPIO);
    assign o_scratch_req = gate_req(i_req, rd_size, !is_simple && user_slot == SLOT_SCRATCH);

    assign o_byte_write  = is_simple && simple_slot == SLOT_BYTE &&
                           i_req.write_size != SIZE_NONE;
    assign o_byte_offset = i_req.addr[SIMPLE_OFFSET_W-1:0];
    assign o_byte_wdata  = i_req.wdata[7:0];

    always_comb begin
        o_rsp.rdata = '0;
        o_rsp.ready = 1'b1;
        if (is_simple) begin
            // Byte slots answer in the same cycle
            if (simple_slot == SLOT_BYTE) begin
                o_rsp.rdata = {{(DATA_W-8){1'b0}}, i_byte_rdata};
            end
        end else begin
            case (user_slot)
                SLOT_GPIO:    o_rsp = i_gpio_rsp;
                SLOT_SCRATCH: o_rsp = i_scratch_rsp;
                default:      o_rsp = '{rdata: '0, ready: 1'b1};
            endcase
        end
    end

endmodule

//--- design/periph_pkg.sv
/*
 * Shared address map, bus structs and size codes for the peripheral block.
 * Modules import this package for their port types and decode constants.
 */
package periph_pkg;

    // Bus widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int PIN_W  = 8;

    // Address map
    localparam int NUM_SLOTS        = 16;
    localparam int SLOT_W           = $clog2(NUM_SLOTS);
    localparam int SIMPLE_SPACE_BIT = 10;
    localparam int USER_SLOT_LSB    = 6;
    localparam int SIMPLE_SLOT_LSB  = 4;
    localparam int USER_OFFSET_W    = 6;
    localparam int SIMPLE_OFFSET_W  = 4;

    // Populated slots
    localparam logic [SLOT_W-1:0] SLOT_GPIO    = 4'd1;
    localparam logic [SLOT_W-1:0] SLOT_SCRATCH = 4'd4;
    // Simple space
    localparam logic [SLOT_W-1:0] SLOT_BYTE    = 4'd0;

    // GPIO register offsets, function selects live at 0x20 + 4 * pin
    localparam logic [USER_OFFSET_W-1:0] GPIO_OUT_OFS = 6'h00;
    localparam logic [USER_OFFSET_W-1:0] GPIO_IN_OFS  = 6'h04;

    // Size codes of the core's read and write requests
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    // Request from the core
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        access_size_e      write_size;
        access_size_e      read_size;
    } bus_req_t;

    // Request seen by one user slot, sizes are NONE unless the slot is addressed
    typedef struct packed {
        logic [USER_OFFSET_W-1:0] offset;
        logic [DATA_W-1:0]        wdata;
        access_size_e             write_size;
        access_size_e             read_size;
    } slot_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ready;
    } slot_rsp_t;

    // Output function of one pin
    typedef struct packed {
        logic              is_simple;
        logic [SLOT_W-1:0] slot;
    } pin_func_t;

endpackage
